// ==== savestate_bus.f ====
hw/ss_pkg.sv
hw/ss_addr_decode.sv
hw/ss_ram_region.sv
hw/ss_cpu_state.sv
hw/ss_read_mux.sv
hw/savestate_bus.sv
bench/tb_clock.sv
bench/savestate_bus_tb.sv

// ==== Makefile ====
SIM        = verilator
TOP        = savestate_bus_tb
FILELIST   = savestate_bus.f
OBJ_DIR    = obj_dir
LOG        = sim.log
SIM_FLAGS  = --binary --timing -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/savestate_bus_tb.sv ====
`timescale 1ns/1ps

module savestate_bus_tb;

    localparam int busy_timeout = 50;
    localparam int reset_timeout = 20;
    localparam int cpu_ram_words = 80;
    localparam int vram_words = 20;

    logic        clk;
    logic        reset;
    logic        reset_req;
    logic [7:0]  ss_bus_addr;
    logic [31:0] ss_bus_in;
    logic        ss_bus_wren;
    logic [31:0] ss_bus_out;
    logic        ss_busy;

    // Expected contents of every mapped word
    logic [31:0] cpu_ram_model [cpu_ram_words];
    logic [31:0] vram_model [vram_words];
    logic [31:0] regs0_model;
    logic [31:0] regs1_model;

    tb_clock u_clock (
        .reset_req (reset_req),
        .clk       (clk),
        .reset     (reset)
    );

    savestate_bus dut (
        .clk         (clk),
        .reset       (reset),
        .ss_bus_addr (ss_bus_addr),
        .ss_bus_in   (ss_bus_in),
        .ss_bus_wren (ss_bus_wren),
        .ss_bus_out  (ss_bus_out),
        .ss_busy     (ss_busy)
    );

    // Word 0x0 from the top holds two zero bits, np, pc, a, b and the i d z c flags
    function automatic logic [31:0] pack_regs0(input logic [4:0] np, input logic [12:0] pc,
                                               input logic [3:0] a, input logic [3:0] b,
                                               input logic [3:0] flags);
        return {2'b00, np, pc, a, b, flags};
    endfunction

    // Word 0x1 holds x, y and sp
    function automatic logic [31:0] pack_regs1(input logic [11:0] x, input logic [11:0] y,
                                               input logic [7:0] sp);
        return {x, y, sp};
    endfunction

    function automatic logic [7:0] region_addr(input int region, input int index);
        return ss_pkg::region_base[region] + 8'(index);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (ss_busy !== 1'b0) begin
            if (cycles >= busy_timeout) begin
                $display("ss_busy did not fall within %0d cycles", busy_timeout);
                $display("Simulation FAILED");
                $fatal(1, "busy timeout");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        next_cycle();
        while (reset !== 1'b0) begin
            if (cycles >= reset_timeout) begin
                $display("reset was not released within %0d cycles", reset_timeout);
                $display("Simulation FAILED");
                $fatal(1, "reset timeout");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    // Decoder stage, any region transfer, then the output register
    task automatic finish_transfer();
        next_cycle();
        wait_not_busy();
        next_cycle();
    endtask

    task automatic ss_write(input logic [7:0] addr, input logic [31:0] data);
        ss_bus_addr = addr;
        ss_bus_in = data;
        ss_bus_wren = 1'b1;
        next_cycle();
        ss_bus_wren = 1'b0;
        finish_transfer();
    endtask

    task automatic ss_read(input logic [7:0] addr, output logic [31:0] data);
        ss_bus_addr = addr;
        next_cycle();
        finish_transfer();
        data = ss_bus_out;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        ss_read(addr, data);
        check_value($sformatf("ss_bus_out @0x%02h", addr), data, expected);
    endtask

    // Address 0x00 is held through reset, so no fetch runs afterwards
    task automatic reset_defaults();
        check_value("ss_busy", {31'b0, ss_busy}, 32'h0);
        regs0_model = pack_regs0(5'h01, 13'h0100, 4'h0, 4'h0, 4'h0);
        regs1_model = pack_regs1(12'h000, 12'h000, 8'h00);
        read_check(8'h00, regs0_model);
        read_check(8'h01, regs1_model);
    endtask

    task automatic cpu_reg_roundtrip();
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            w = $urandom();
            // Half the words set the two unused top bits
            if (i % 2 == 0) begin
                w[31:30] = 2'b11;
            end
            ss_write(8'h00, w);
            regs0_model = pack_regs0(w[29:25], w[24:12], w[11:8], w[7:4], w[3:0]);
            read_check(8'h00, regs0_model);
            w = $urandom();
            ss_write(8'h01, w);
            regs1_model = pack_regs1(w[31:20], w[19:8], w[7:0]);
            read_check(8'h01, regs1_model);
        end
        // Word 0x1 writes leave word 0x0 alone
        read_check(8'h00, regs0_model);
    endtask

    task automatic cpu_ram_roundtrip();
        for (int i = 0; i < cpu_ram_words; i++) begin
            cpu_ram_model[i] = $urandom();
            ss_write(region_addr(0, i), cpu_ram_model[i]);
        end
        for (int i = cpu_ram_words - 1; i >= 0; i--) begin
            read_check(region_addr(0, i), cpu_ram_model[i]);
        end
    endtask

    task automatic video_ram_roundtrip();
        for (int i = 0; i < vram_words; i++) begin
            vram_model[i] = $urandom();
            ss_write(region_addr(1, i), vram_model[i]);
        end
        for (int i = 0; i < vram_words; i++) begin
            read_check(region_addr(1, i), vram_model[i]);
        end
        // Spread sample over CPU RAM
        for (int i = 0; i < 10; i++) begin
            read_check(region_addr(0, (i * 11) % cpu_ram_words),
                       cpu_ram_model[(i * 11) % cpu_ram_words]);
        end
    endtask

    task automatic unmapped_words();
        logic [7:0] addrs [3] = '{8'h02, 8'h0F, 8'h80};
        for (int i = 0; i < 3; i++) begin
            read_check(addrs[i], 32'h0);
            ss_write(addrs[i], $urandom());
            read_check(addrs[i], 32'h0);
        end
        read_check(8'h00, regs0_model);
        read_check(8'h01, regs1_model);
        read_check(region_addr(0, 0), cpu_ram_model[0]);
        read_check(region_addr(0, cpu_ram_words - 1), cpu_ram_model[cpu_ram_words - 1]);
        read_check(region_addr(1, 0), vram_model[0]);
        read_check(region_addr(1, vram_words - 1), vram_model[vram_words - 1]);
    endtask

    task automatic reset_restore();
        ss_bus_addr = 8'h00;
        reset_req = 1'b1;
        next_cycle();
        reset_req = 1'b0;
        wait_reset_done();
        reset_defaults();
    endtask

    initial begin
        ss_bus_addr = 8'h00;
        ss_bus_in = 32'h0;
        ss_bus_wren = 1'b0;
        reset_req = 1'b0;
        void'($urandom(32'he2ae907e));

        wait_reset_done();
        reset_defaults();
        cpu_reg_roundtrip();
        cpu_ram_roundtrip();
        video_ram_roundtrip();
        unmapped_words();
        reset_restore();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100,
    parameter int reset_cycles = 4
) (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    int reset_count;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        reset_count = reset_cycles;
    end

    // Reset spans reset_cycles rising edges, at start and on request
    always @(posedge clk) begin
        if (reset_req) begin
            reset_count <= reset_cycles;
            reset <= 1'b1;
        end else if (reset_count > 1) begin
            reset_count <= reset_count - 1;
        end else begin
            reset_count <= 0;
            reset <= 1'b0;
        end
    end

endmodule

// ==== hw/savestate_bus.sv ====
`timescale 1ns/1ps

module savestate_bus (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ss_pkg::ss_addr_width-1:0] ss_bus_addr,
    input  logic [ss_pkg::ss_data_width-1:0] ss_bus_in,
    input  logic                             ss_bus_wren,
    output logic [ss_pkg::ss_data_width-1:0] ss_bus_out,
    output logic                             ss_busy
);

    logic [ss_pkg::num_regions-1:0]   region_sel;
    logic [ss_pkg::offset_width-1:0]  word_offset;
    logic                             cmd_write;
    logic                             cmd_fetch;
    logic [1:0]                       reg_sel;
    logic                             reg_write;
    logic [ss_pkg::ss_data_width-1:0] region_rd_word [ss_pkg::num_regions];
    logic [ss_pkg::num_regions-1:0]   region_busy;
    logic [ss_pkg::ss_data_width-1:0] regs0_word;
    logic [ss_pkg::ss_data_width-1:0] regs1_word;

    ss_addr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .ss_bus_addr (ss_bus_addr),
        .ss_bus_wren (ss_bus_wren),
        .region_sel  (region_sel),
        .word_offset (word_offset),
        .cmd_write   (cmd_write),
        .cmd_fetch   (cmd_fetch),
        .reg_sel     (reg_sel),
        .reg_write   (reg_write)
    );

    // One nibble RAM per region: CPU RAM, video RAM
    for (genvar g = 0; g < ss_pkg::num_regions; g++) begin : g_region
        ss_ram_region #(
            .depth_words (ss_pkg::region_words[g])
        ) u_region (
            .clk         (clk),
            .reset       (reset),
            .sel         (region_sel[g]),
            .word_offset (word_offset),
            .cmd_write   (cmd_write),
            .cmd_fetch   (cmd_fetch),
            .wr_word     (ss_bus_in),
            .rd_word     (region_rd_word[g]),
            .busy        (region_busy[g])
        );
    end

    ss_cpu_state u_cpu_state (
        .clk        (clk),
        .reset      (reset),
        .reg_sel    (reg_sel),
        .reg_write  (reg_write),
        .wr_word    (ss_bus_in),
        .regs0_word (regs0_word),
        .regs1_word (regs1_word)
    );

    ss_read_mux u_read_mux (
        .clk             (clk),
        .reset           (reset),
        .region_sel      (region_sel),
        .reg_sel         (reg_sel),
        .region_words_in (region_rd_word),
        .region_busy     (region_busy),
        .regs0_word      (regs0_word),
        .regs1_word      (regs1_word),
        .ss_bus_out      (ss_bus_out),
        .ss_busy         (ss_busy)
    );

endmodule

// ==== hw/ss_read_mux.sv ====
`timescale 1ns/1ps

module ss_read_mux (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ss_pkg::num_regions-1:0]   region_sel,
    input  logic [1:0]                       reg_sel,
    input  logic [ss_pkg::ss_data_width-1:0] region_words_in [ss_pkg::num_regions],
    input  logic [ss_pkg::num_regions-1:0]   region_busy,
    input  logic [ss_pkg::ss_data_width-1:0] regs0_word,
    input  logic [ss_pkg::ss_data_width-1:0] regs1_word,
    output logic [ss_pkg::ss_data_width-1:0] ss_bus_out,
    output logic                             ss_busy
);

    logic [ss_pkg::ss_data_width-1:0] next_word;

    // Selects are one-hot, unmapped addresses fall through to zero
    always_comb begin
        next_word = '0;
        if (reg_sel[0]) begin
            next_word = regs0_word;
        end
        if (reg_sel[1]) begin
            next_word = regs1_word;
        end
        for (int i = 0; i < ss_pkg::num_regions; i++) begin
            if (region_sel[i]) begin
                next_word = region_words_in[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ss_bus_out <= '0;
        end else begin
            ss_bus_out <= next_word;
        end
    end

    assign ss_busy = |region_busy;

endmodule

// ==== hw/ss_cpu_state.sv ====
`timescale 1ns/1ps

module ss_cpu_state (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [1:0]                       reg_sel,
    input  logic                             reg_write,
    input  logic [ss_pkg::ss_data_width-1:0] wr_word,
    output logic [ss_pkg::ss_data_width-1:0] regs0_word,
    output logic [ss_pkg::ss_data_width-1:0] regs1_word
);

    logic [ss_pkg::ss_data_width-1:0] wr_q;

    logic [ss_pkg::np_width-1:0]      np;
    logic [ss_pkg::pc_width-1:0]      pc;
    logic [ss_pkg::acc_width-1:0]     a;
    logic [ss_pkg::acc_width-1:0]     b;
    logic [ss_pkg::index_width-1:0]   x;
    logic [ss_pkg::index_width-1:0]   y;
    logic [ss_pkg::sp_width-1:0]      sp;
    logic                             interrupt;
    logic                             decimal;
    logic                             zero;
    logic                             carry;

    // Data sampled on the same edge as the host strobe
    always_ff @(posedge clk) begin
        wr_q <= wr_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            np <= ss_pkg::np_reset;
            pc <= ss_pkg::pc_reset;
            a <= '0;
            b <= '0;
            x <= '0;
            y <= '0;
            sp <= '0;
            interrupt <= 1'b0;
            decimal <= 1'b0;
            zero <= 1'b0;
            carry <= 1'b0;
        end else if (reg_write) begin
            // Word 0x0, top two bits dropped
            if (reg_sel[0]) begin
                {np, pc, a, b, interrupt, decimal, zero, carry} <=
                    wr_q[ss_pkg::ss_data_width-3:0];
            end
            // Word 0x1
            if (reg_sel[1]) begin
                {x, y, sp} <= wr_q;
            end
        end
    end

    assign regs0_word = {2'b00, np, pc, a, b, interrupt, decimal, zero, carry};
    assign regs1_word = {x, y, sp};

endmodule

// ==== hw/ss_ram_region.sv ====
`timescale 1ns/1ps

module ss_ram_region #(
    parameter int depth_words = 80
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sel,
    input  logic [ss_pkg::offset_width-1:0]  word_offset,
    input  logic                             cmd_write,
    input  logic                             cmd_fetch,
    input  logic [ss_pkg::ss_data_width-1:0] wr_word,
    output logic [ss_pkg::ss_data_width-1:0] rd_word,
    output logic                             busy
);

    localparam int step_width = $clog2(ss_pkg::nibbles_per_word);
    localparam int depth_nibbles = depth_words * ss_pkg::nibbles_per_word;
    localparam int nib_addr_width = $clog2(depth_nibbles);
    localparam logic [step_width:0] last_write_step =
        (step_width + 1)'(ss_pkg::nibbles_per_word - 1);
    localparam logic [step_width:0] last_fetch_step =
        (step_width + 1)'(ss_pkg::nibbles_per_word);

    logic [ss_pkg::nibble_width-1:0]         mem [depth_nibbles];
    logic [ss_pkg::nibble_width-1:0]         rd_nib_q;
    logic [ss_pkg::nibble_width-1:0]         shift_nib;
    logic [ss_pkg::ss_data_width-1:0]        data_q;
    logic [step_width:0]                     step_q;
    logic                                    writing_q;
    logic                                    start_write;
    logic                                    start_fetch;
    logic                                    mem_we;
    logic [ss_pkg::offset_width+step_width-1:0] nib_addr_full;
    logic [nib_addr_width-1:0]               nib_addr;

    // Writes win over a fetch issued in the same cycle
    assign start_write = sel && cmd_write && !busy;
    assign start_fetch = sel && cmd_fetch && !cmd_write && !busy;
    assign mem_we = start_write || (busy && writing_q);

    // Word offset selects eight cells, the step picks one of them
    assign nib_addr_full = {word_offset, step_q[step_width-1:0]};
    assign nib_addr = nib_addr_full[nib_addr_width-1:0];

    // Nibble entering rd_word: the one being written, or the one read back
    assign shift_nib = mem_we ? data_q[ss_pkg::nibble_width-1:0] : rd_nib_q;

    // Transfer sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            writing_q <= 1'b0;
            step_q <= '0;
        end else if (start_write) begin
            busy <= 1'b1;
            writing_q <= 1'b1;
            step_q <= 1'b1;
        end else if (start_fetch) begin
            busy <= 1'b1;
            writing_q <= 1'b0;
            step_q <= 1'b1;
        end else if (busy) begin
            if (writing_q ? (step_q == last_write_step) : (step_q == last_fetch_step)) begin
                busy <= 1'b0;
                writing_q <= 1'b0;
                step_q <= '0;
            end else begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    // Single-port nibble RAM, synchronous read
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[nib_addr] <= data_q[ss_pkg::nibble_width-1:0];
        end
        rd_nib_q <= mem[nib_addr];
    end

    // Idle: track the bus data, so the word sampled with the strobe is kept
    always_ff @(posedge clk) begin
        if (mem_we) begin
            data_q <= data_q >> ss_pkg::nibble_width;
        end else if (!busy) begin
            data_q <= wr_word;
        end
    end

    // First nibble ends up in the low bits after eight shifts
    always_ff @(posedge clk) begin
        if (start_write || busy) begin
            rd_word <= {shift_nib, rd_word[ss_pkg::ss_data_width-1:ss_pkg::nibble_width]};
        end
    end

endmodule

// ==== hw/ss_addr_decode.sv ====
`timescale 1ns/1ps

module ss_addr_decode (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ss_pkg::ss_addr_width-1:0] ss_bus_addr,
    input  logic                             ss_bus_wren,
    output logic [ss_pkg::num_regions-1:0]   region_sel,
    output logic [ss_pkg::offset_width-1:0]  word_offset,
    output logic                             cmd_write,
    output logic                             cmd_fetch,
    output logic [1:0]                       reg_sel,
    output logic                             reg_write
);

    logic [ss_pkg::ss_addr_width-1:0] addr_q;
    logic [ss_pkg::ss_addr_width-1:0] addr_prev_q;
    logic                             wren_q;
    logic                             fetch_init_q;
    logic                             region_hit;

    // Address history, used to spot a change of word
    always_ff @(posedge clk) begin
        addr_q <= ss_bus_addr;
        addr_prev_q <= addr_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wren_q <= 1'b0;
            fetch_init_q <= 1'b1;
        end else begin
            wren_q <= ss_bus_wren;
            fetch_init_q <= 1'b0;
        end
    end

    // Region lookup against the table
    always_comb begin
        logic [ss_pkg::ss_addr_width-1:0] diff;
        region_sel = '0;
        word_offset = '0;
        diff = '0;
        for (int i = 0; i < ss_pkg::num_regions; i++) begin
            if (addr_q >= ss_pkg::region_base[i] &&
                addr_q < ss_pkg::region_base[i] + ss_pkg::region_words[i]) begin
                region_sel[i] = 1'b1;
                diff = addr_q - ss_pkg::region_base[i];
                word_offset = diff[ss_pkg::offset_width-1:0];
            end
        end
    end

    assign reg_sel[0] = (addr_q == ss_pkg::ss_addr_cpu_regs0);
    assign reg_sel[1] = (addr_q == ss_pkg::ss_addr_cpu_regs1);

    assign region_hit = |region_sel;

    // Strobes to unmapped words go nowhere
    assign cmd_write = wren_q && region_hit;
    assign reg_write = wren_q && (|reg_sel);

    // Refresh the read word whenever a new RAM word is addressed
    assign cmd_fetch = region_hit && (fetch_init_q || addr_q != addr_prev_q);

endmodule

// ==== hw/ss_pkg.sv ====
package ss_pkg;

    // Host bus
    localparam int ss_addr_width = 8;
    localparam int ss_data_width = 32;

    // RAM cells are one nibble wide
    localparam int nibble_width = 4;
    localparam int nibbles_per_word = ss_data_width / nibble_width;

    // RAM regions: CPU RAM, then video RAM
    localparam int num_regions = 2;
    localparam logic [ss_addr_width-1:0] region_base [num_regions] = '{8'h10, 8'h60};
    localparam int region_words [num_regions] = '{80, 20};
    localparam int max_region_words = 80;

    // Word offset inside the largest region
    localparam int offset_width = $clog2(max_region_words);

    // CPU register words
    localparam logic [ss_addr_width-1:0] ss_addr_cpu_regs0 = 8'h00;
    localparam logic [ss_addr_width-1:0] ss_addr_cpu_regs1 = 8'h01;

    // CPU register field widths
    localparam int pc_width = 13;
    localparam int np_width = 5;
    localparam int acc_width = 4;
    localparam int index_width = 12;
    localparam int sp_width = 8;

    // Power-on values
    localparam logic [pc_width-1:0] pc_reset = 13'h0100;
    localparam logic [np_width-1:0] np_reset = 5'h01;

endpackage
